// ==== logic/sram_pkg.sv ====
package sram_pkg;

    // bus widths
    localparam int data_w = 32;
    localparam int addr_w = 32;
    localparam int strb_w = data_w / 8;

    typedef enum logic {
        mem_read  = 1'b0,
        mem_write = 1'b1
    } mem_op_e;

    // AXI-lite response codes, only the two used here
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    typedef enum logic [1:0] {
        eng_idle = 2'b00,
        eng_wait = 2'b01,
        eng_done = 2'b10
    } eng_state_e;

    // one request from the capture side to the engine
    typedef struct packed {
        mem_op_e             op;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        logic [strb_w-1:0]   wstrb;
    } mem_req_t;

    // one response from the engine to the output side
    typedef struct packed {
        mem_op_e             op;
        logic [data_w-1:0]   rdata;
        axil_resp_e          resp;
    } mem_rsp_t;

endpackage

// ==== logic/axil_req_capture.sv ====
`timescale 1ns/1ns

module axil_req_capture
    import sram_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic [addr_w-1:0]   araddr,
    input  logic                arvalid,
    output logic                arready,
    input  logic [addr_w-1:0]   awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [data_w-1:0]   wdata,
    input  logic [strb_w-1:0]   wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic                req_valid,
    output mem_req_t            req,
    input  logic                req_ready
);

    logic                active;
    logic                rd_full;
    logic                rd_elig;
    logic [addr_w-1:0]   rd_addr;
    logic                aw_full;
    logic [addr_w-1:0]   aw_addr;
    logic                w_full;
    logic [data_w-1:0]   w_data;
    logic [strb_w-1:0]   w_strb;
    logic                wr_elig;
    logic                holding;
    mem_op_e             hold_op;
    mem_op_e             last_op;
    mem_op_e             grant_op;
    logic                take;
    logic                rd_take;
    logic                wr_take;

    // readies come up one clock after reset release
    assign arready = active & ~rd_full;
    assign awready = active & ~aw_full;
    assign wready  = active & ~w_full;

    // once offered, a request keeps its grant until accepted
    always_comb begin
        if (holding) begin
            grant_op = hold_op;
        end else if (rd_elig && wr_elig) begin
            grant_op = (last_op == mem_write) ? mem_read : mem_write;
        end else if (rd_elig) begin
            grant_op = mem_read;
        end else begin
            grant_op = mem_write;
        end
    end

    assign req_valid = rd_elig | wr_elig;
    assign take      = req_valid & req_ready;
    assign rd_take   = take & (grant_op == mem_read);
    assign wr_take   = take & (grant_op == mem_write);

    always_comb begin
        req.op = grant_op;
        if (grant_op == mem_read) begin
            req.addr  = rd_addr;
            req.wdata = '0;
            req.wstrb = '0;
        end else begin
            req.addr  = aw_addr;
            req.wdata = w_data;
            req.wstrb = w_strb;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active  <= 1'b0;
            rd_full <= 1'b0;
            rd_elig <= 1'b0;
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            wr_elig <= 1'b0;
            holding <= 1'b0;
            hold_op <= mem_read;
            last_op <= mem_write;
        end else begin
            active  <= 1'b1;
            rd_elig <= rd_full & ~rd_take;
            wr_elig <= aw_full & w_full & ~wr_take;
            holding <= req_valid & ~req_ready;
            hold_op <= grant_op;
            if (arvalid && arready) begin
                rd_full <= 1'b1;
            end else if (rd_take) begin
                rd_full <= 1'b0;
            end
            if (awvalid && awready) begin
                aw_full <= 1'b1;
            end else if (wr_take) begin
                aw_full <= 1'b0;
            end
            if (wvalid && wready) begin
                w_full <= 1'b1;
            end else if (wr_take) begin
                w_full <= 1'b0;
            end
            if (take) begin
                last_op <= grant_op;
            end
        end
    end

    // holding registers
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
        if (awvalid && awready) begin
            aw_addr <= awaddr;
        end
        if (wvalid && wready) begin
            w_data <= wdata;
            w_strb <= wstrb;
        end
    end

endmodule

// ==== logic/sram_access_engine.sv ====
`timescale 1ns/1ns

module sram_access_engine
    import sram_pkg::*;
#(
    parameter int MEM_WORDS      = 256,
    parameter int ACCESS_LATENCY = 4
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  mem_req_t   req,
    output logic       req_ready,
    output logic       rsp_valid,
    output mem_rsp_t   rsp,
    input  logic       rsp_ready
);

    localparam int idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int cnt_w = $clog2(ACCESS_LATENCY + 1);

    eng_state_e          state;
    logic [cnt_w-1:0]    cnt;
    mem_req_t            cur_req;
    mem_rsp_t            rsp_q;
    logic [addr_w-3:0]   word_idx;
    logic [idx_w-1:0]    mem_idx;
    logic                in_range;
    logic                do_access;

    // word array, contents undefined until written
    logic [data_w-1:0]   mem [MEM_WORDS];

    assign req_ready = (state == eng_idle);
    assign rsp_valid = (state == eng_done);
    assign rsp       = rsp_q;

    // byte address to word index
    assign word_idx  = cur_req.addr[addr_w-1:2];
    assign mem_idx   = word_idx[idx_w-1:0];
    assign in_range  = ({2'b00, word_idx} < addr_w'(MEM_WORDS));
    assign do_access = (state == eng_wait) && (cnt == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= eng_idle;
            cnt   <= '0;
        end else begin
            case (state)
                eng_idle: begin
                    if (req_valid) begin
                        state <= eng_wait;
                        cnt   <= cnt_w'(ACCESS_LATENCY - 1);
                    end
                end
                eng_wait: begin
                    if (cnt == '0) begin
                        state <= eng_done;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                eng_done: begin
                    if (rsp_ready) begin
                        state <= eng_idle;
                    end
                end
                default: begin
                    state <= eng_idle;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cur_req <= req;
        end
        if (do_access) begin
            rsp_q.op <= cur_req.op;
            if (in_range && cur_req.op == mem_read) begin
                rsp_q.rdata <= mem[mem_idx];
            end else begin
                rsp_q.rdata <= '0;
            end
            rsp_q.resp <= in_range ? resp_okay : resp_slverr;
        end
    end

    // strobed write, out of range writes are dropped
    always_ff @(posedge clk) begin
        if (do_access && in_range && cur_req.op == mem_write) begin
            for (int b = 0; b < strb_w; b++) begin
                if (cur_req.wstrb[b]) begin
                    mem[mem_idx][b*8 +: 8] <= cur_req.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/axil_resp_drive.sv ====
`timescale 1ns/1ns

module axil_resp_drive
    import sram_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                rsp_valid,
    input  mem_rsp_t            rsp,
    output logic                rsp_ready,
    output logic [data_w-1:0]   rdata,
    output axil_resp_e          rresp,
    output logic                rvalid,
    input  logic                rready,
    output axil_resp_e          bresp,
    output logic                bvalid,
    input  logic                bready
);

    logic   rsp_take;
    logic   r_load;
    logic   b_load;

    // ready only when the matching slot is free
    assign rsp_ready = (rsp.op == mem_read) ? ~rvalid : ~bvalid;
    assign rsp_take  = rsp_valid & rsp_ready;
    assign r_load    = rsp_take & (rsp.op == mem_read);
    assign b_load    = rsp_take & (rsp.op == mem_write);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (r_load) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (b_load) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // payload held until the slot is accepted
    always_ff @(posedge clk) begin
        if (r_load) begin
            rdata <= rsp.rdata;
            rresp <= rsp.resp;
        end
        if (b_load) begin
            bresp <= rsp.resp;
        end
    end

endmodule

// ==== logic/axil_sram_top.sv ====
`timescale 1ns/1ns

module axil_sram_top
    import sram_pkg::*;
#(
    parameter int MEM_WORDS      = 256,
    parameter int ACCESS_LATENCY = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [addr_w-1:0]   araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [data_w-1:0]   rdata,
    output axil_resp_e          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  logic [addr_w-1:0]   awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [data_w-1:0]   wdata,
    input  logic [strb_w-1:0]   wstrb,
    input  logic                wvalid,
    output logic                wready,
    output axil_resp_e          bresp,
    output logic                bvalid,
    input  logic                bready
);

    logic       req_valid;
    logic       req_ready;
    mem_req_t   req;
    logic       rsp_valid;
    logic       rsp_ready;
    mem_rsp_t   rsp;

    axil_req_capture u_capture (
        .clk       (clk),
        .arst_n    (arst_n),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready)
    );

    sram_access_engine #(
        .MEM_WORDS      (MEM_WORDS),
        .ACCESS_LATENCY (ACCESS_LATENCY)
    ) u_engine (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    axil_resp_drive u_resp (
        .clk       (clk),
        .arst_n    (arst_n),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

// ==== dv/axil_sram_properties.sv ====
`timescale 1ns/1ns

module axil_sram_properties
    import sram_pkg::*;
(
    input logic                clk,
    input logic                arst_n,
    input logic [data_w-1:0]   rdata,
    input axil_resp_e          rresp,
    input logic                rvalid,
    input logic                rready,
    input logic                bvalid,
    input logic                bready
);

    // valid held until accepted
    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!arst_n) rvalid && !rready |=> rvalid
    ) else $error("rvalid dropped before rready");

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!arst_n) bvalid && !bready |=> bvalid
    ) else $error("bvalid dropped before bready");

    // r payload frozen while stalled
    a_r_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> $stable(rdata) && $stable(rresp)
    ) else $error("rdata or rresp changed while rvalid waited");

    a_reset_quiet: assert property (
        @(posedge clk) !arst_n |-> !rvalid && !bvalid
    ) else $error("response valid seen during reset");

endmodule

bind axil_sram_top axil_sram_properties u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .bvalid (bvalid),
    .bready (bready)
);

// ==== dv/axil_sram_tb.sv ====
`timescale 1ns/1ns

module axil_sram_tb
    import sram_pkg::*;
();

    localparam int mem_words = 64;
    localparam int latency   = 4;
    localparam int idx_w     = $clog2(mem_words);
    localparam int timeout   = 200;

    typedef struct packed {
        mem_op_e             op;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        logic [strb_w-1:0]   wstrb;
        logic                aw_first;
        logic                bp;
    } stim_t;

    logic                clk;
    logic                arst_n;
    logic [addr_w-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    logic [data_w-1:0]   rdata;
    axil_resp_e          rresp;
    logic                rvalid;
    logic                rready;
    logic [addr_w-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    logic [data_w-1:0]   wdata;
    logic [strb_w-1:0]   wstrb;
    logic                wvalid;
    logic                wready;
    axil_resp_e          bresp;
    logic                bvalid;
    logic                bready;

    stim_t               stim[$];
    logic [data_w-1:0]   model [mem_words];
    logic [data_w-1:0]   exp_rdata[$];
    axil_resp_e          exp_rresp[$];
    axil_resp_e          exp_bresp[$];
    logic [31:0]         rng_state = 32'h97eb;
    logic                bp_mode;
    int                  mismatches;
    int                  protocol_errs;

    axil_sram_top #(
        .MEM_WORDS      (mem_words),
        .ACCESS_LATENCY (latency)
    ) UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            mismatches++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic abort_on_stall(input string chan);
        $display("Timeout: the %s channel made no progress", chan);
        $display("Test failed");
        $finish;
    endtask

    task automatic add_entry(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb,
                             input logic aw_first, input logic bp);
        stim_t e;
        e.op       = op;
        e.addr     = addr;
        e.wdata    = data;
        e.wstrb    = strb;
        e.aw_first = aw_first;
        e.bp       = bp;
        stim.push_back(e);
    endtask

    task automatic build_table();
        // full-strobe fill of words 0..3 with mixed aw/w order
        for (int i = 0; i < 4; i++) begin
            add_entry(mem_write, 32'(i * 4), next_rand(), 4'hf, i[0], 1'b0);
        end
        add_entry(mem_write, 32'h10, next_rand(), 4'hf, 1'b1, 1'b0);
        add_entry(mem_read, 32'h10, '0, '0, 1'b0, 1'b0);
        add_entry(mem_write, 32'h14, next_rand(), 4'hf, 1'b0, 1'b0);
        add_entry(mem_read, 32'h14, '0, '0, 1'b0, 1'b0);
        // partial strobes
        add_entry(mem_write, 32'h20, next_rand(), 4'hf, 1'b1, 1'b0);
        add_entry(mem_write, 32'h20, next_rand(), 4'b0011, 1'b0, 1'b0);
        add_entry(mem_read, 32'h20, '0, '0, 1'b0, 1'b0);
        add_entry(mem_write, 32'h20, next_rand(), 4'b1000, 1'b1, 1'b0);
        add_entry(mem_read, 32'h20, '0, '0, 1'b0, 1'b0);
        add_entry(mem_write, 32'h24, next_rand(), 4'hf, 1'b0, 1'b0);
        add_entry(mem_write, 32'h24, next_rand(), 4'b0101, 1'b1, 1'b0);
        add_entry(mem_read, 32'h24, '0, '0, 1'b0, 1'b0);
        // out of range accesses then a valid read
        add_entry(mem_write, 32'h100, next_rand(), 4'hf, 1'b1, 1'b0);
        add_entry(mem_read, 32'h100, '0, '0, 1'b0, 1'b0);
        add_entry(mem_read, 32'hffc, '0, '0, 1'b0, 1'b0);
        add_entry(mem_read, 32'h10, '0, '0, 1'b0, 1'b0);
        // back to back writes and reads on disjoint words under back-pressure
        for (int i = 0; i < 8; i++) begin
            add_entry(mem_write, 32'h40 + 32'(i * 4), next_rand(), 4'hf, i[1], 1'b1);
            add_entry(mem_read, 32'((i % 4) * 4), '0, '0, 1'b0, 1'b1);
        end
        for (int i = 0; i < 8; i++) begin
            add_entry(mem_read, 32'h40 + 32'(i * 4), '0, '0, 1'b0, 1'b0);
        end
    endtask

    task automatic wait_accept(input string chan);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (chan == "ar") begin
                done = arready;
            end else if (chan == "aw") begin
                done = awready;
            end else begin
                done = wready;
            end
            if (!done && cycles >= timeout) begin
                abort_on_stall(chan);
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_rdata.size() != 0 || exp_bresp.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles >= timeout * 4) begin
                if (exp_rdata.size() != 0) begin
                    abort_on_stall("r");
                end else begin
                    abort_on_stall("b");
                end
            end
        end
        @(posedge clk);
    endtask

    task automatic issue_read(input logic [addr_w-1:0] addr);
        if (addr < 32'(mem_words * 4)) begin
            exp_rdata.push_back(model[addr[idx_w+1:2]]);
            exp_rresp.push_back(resp_okay);
        end else begin
            exp_rdata.push_back('0);
            exp_rresp.push_back(resp_slverr);
        end
        araddr  <= addr;
        arvalid <= 1'b1;
        wait_accept("ar");
        arvalid <= 1'b0;
    endtask

    task automatic issue_write(input stim_t e);
        if (e.addr < 32'(mem_words * 4)) begin
            // merge strobed bytes into the model word
            for (int b = 0; b < strb_w; b++) begin
                if (e.wstrb[b]) begin
                    model[e.addr[idx_w+1:2]][b*8 +: 8] = e.wdata[b*8 +: 8];
                end
            end
            exp_bresp.push_back(resp_okay);
        end else begin
            exp_bresp.push_back(resp_slverr);
        end
        for (int step = 0; step < 2; step++) begin
            if ((step == 0) == e.aw_first) begin
                awaddr  <= e.addr;
                awvalid <= 1'b1;
                wait_accept("aw");
                awvalid <= 1'b0;
            end else begin
                wdata  <= e.wdata;
                wstrb  <= e.wstrb;
                wvalid <= 1'b1;
                wait_accept("w");
                wvalid <= 1'b0;
            end
        end
    endtask

    // random ready toggling while back-pressure is on
    initial begin
        logic [31:0] r;
        rready = 1'b0;
        bready = 1'b0;
        forever begin
            @(posedge clk);
            r = next_rand();
            rready <= bp_mode ? r[0] : 1'b1;
            bready <= bp_mode ? r[7] : 1'b1;
        end
    end

    // response monitor checking issue order per channel
    initial begin
        forever begin
            @(posedge clk);
            if (arst_n && rvalid && rready) begin
                if (exp_rdata.size() == 0) begin
                    protocol_errs++;
                    $display("Extra response on the r channel with nothing outstanding");
                end else begin
                    check_value(rdata, exp_rdata.pop_front(), "read data");
                    check_value(32'(rresp), 32'(exp_rresp.pop_front()), "read response");
                end
            end
            if (arst_n && bvalid && bready) begin
                if (exp_bresp.size() == 0) begin
                    protocol_errs++;
                    $display("Extra response on the b channel with nothing outstanding");
                end else begin
                    check_value(32'(bresp), 32'(exp_bresp.pop_front()), "write response");
                end
            end
        end
    end

    initial begin
        arst_n        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bp_mode       = 1'b0;
        mismatches    = 0;
        protocol_errs = 0;
        for (int i = 0; i < mem_words; i++) begin
            model[i] = '0;
        end
        build_table();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);
        check_value(32'(arready), 32'd1, "arready after reset");
        check_value(32'(awready), 32'd1, "awready after reset");
        check_value(32'(wready), 32'd1, "wready after reset");
        check_value(32'(rvalid), 32'd0, "rvalid after reset");
        check_value(32'(bvalid), 32'd0, "bvalid after reset");
        foreach (stim[i]) begin
            if (!stim[i].bp) begin
                wait_drain();
            end
            bp_mode <= stim[i].bp;
            if (stim[i].op == mem_read) begin
                issue_read(stim[i].addr);
            end else begin
                issue_write(stim[i]);
            end
            if (!stim[i].bp) begin
                wait_drain();
            end
        end
        wait_drain();
        repeat (6) @(posedge clk);
        $display("Done: %0d value mismatches, %0d protocol errors", mismatches, protocol_errs);
        if (mismatches == 0 && protocol_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
logic/sram_pkg.sv
logic/axil_req_capture.sv
logic/sram_access_engine.sv
logic/axil_resp_drive.sv
logic/axil_sram_top.sv
dv/axil_sram_properties.sv
dv/axil_sram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module axil_sram_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "compile failed"
    exit 1
fi

./obj_dir/Vaxil_sram_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
